// File: rtl/vec_cfg_pkg.sv
/* Fixed datapath and register file sizes shared by every block of the vector unit
   Referenced by scoped name, never imported */
`default_nettype none

package vec_cfg_pkg;

    localparam int DATA_W   = 32;
    localparam int VREG_NUM = 8;
    localparam int VREG_W   = 3;
    localparam int ROW_W    = 4;  // Row index field, up to 16 rows per vector

    typedef logic [VREG_W-1:0] vreg_idx_t;
    typedef logic [DATA_W-1:0] elem_t;

endpackage

`default_nettype wire

// File: rtl/vec_isa_pkg.sv
/* Instruction word, opcodes, ALU functions and the per-row control word
   that the driver sends through the interconnect into every lane */
`default_nettype none

package vec_isa_pkg;

    typedef enum logic [2:0] {
        OP_ALU        = 3'd0,
        OP_LOAD       = 3'd1,
        OP_STORE      = 3'd2,
        OP_SLIDE_UP   = 3'd3,
        OP_SLIDE_DOWN = 3'd4
    } opcode_e;

    typedef enum logic [2:0] {
        FN_ADD  = 3'd0,
        FN_SUB  = 3'd1,
        FN_AND  = 3'd2,
        FN_OR   = 3'd3,
        FN_XOR  = 3'd4,
        FN_SLL  = 3'd5,
        FN_SRL  = 3'd6,
        FN_MINU = 3'd7
    } alu_fn_e;

    // ALU and slide view
    typedef struct packed {
        opcode_e                opcode;
        alu_fn_e                fn;
        vec_cfg_pkg::vreg_idx_t vd;
        vec_cfg_pkg::vreg_idx_t vs1;
        vec_cfg_pkg::vreg_idx_t vs2;
        logic                   rsvd;
    } alu_fmt_t;

    // Load and store view
    typedef struct packed {
        opcode_e                opcode;
        vec_cfg_pkg::vreg_idx_t vreg;
        logic [9:0]             rsvd;
    } mem_fmt_t;

    typedef union packed {
        alu_fmt_t alu;
        mem_fmt_t mem;
    } vec_instr_u;

    typedef enum logic [1:0] {
        WB_NONE  = 2'd0,
        WB_ALU   = 2'd1,
        WB_LOAD  = 2'd2,
        WB_SLIDE = 2'd3
    } wb_src_e;

    typedef struct packed {
        logic                         valid;
        logic [vec_cfg_pkg::ROW_W-1:0] row;
        vec_cfg_pkg::vreg_idx_t       vs1;
        vec_cfg_pkg::vreg_idx_t       vs2;
        vec_cfg_pkg::vreg_idx_t       vd;
        alu_fn_e                      fn;
        wb_src_e                      wb_src;
        logic                         slide_up;   // Ring direction for slides
        logic                         store_row;  // Row goes out on the store port
    } row_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/lane_alu.sv
/* Combinational element ALU of a lane */
`timescale 1ns/1ps
`default_nettype none

module lane_alu (
    input  wire vec_isa_pkg::alu_fn_e fn_i,
    input  wire vec_cfg_pkg::elem_t   a_i,
    input  wire vec_cfg_pkg::elem_t   b_i,
    output vec_cfg_pkg::elem_t        y_o
);

    always_comb begin
        case (fn_i)
            vec_isa_pkg::FN_ADD:  y_o = a_i + b_i;
            vec_isa_pkg::FN_SUB:  y_o = a_i - b_i;
            vec_isa_pkg::FN_AND:  y_o = a_i & b_i;
            vec_isa_pkg::FN_OR:   y_o = a_i | b_i;
            vec_isa_pkg::FN_XOR:  y_o = a_i ^ b_i;
            vec_isa_pkg::FN_SLL:  y_o = a_i << b_i[4:0];  // Shift amount from low bits of b
            vec_isa_pkg::FN_SRL:  y_o = a_i >> b_i[4:0];
            vec_isa_pkg::FN_MINU: y_o = (a_i < b_i) ? a_i : b_i;
            default:              y_o = a_i;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/vrf_bank.sv
/* Register-file bank of one lane, two registered read ports and one write port */
`timescale 1ns/1ps
`default_nettype none

module vrf_bank #(
    parameter int  ELEMS_PER_LANE = 2,
    localparam int DEPTH          = vec_cfg_pkg::VREG_NUM * ELEMS_PER_LANE,
    localparam int ADDR_W         = $clog2(DEPTH)
) (
    input  wire                     clk_i,
    input  wire [ADDR_W-1:0]        raddr_a_i,
    input  wire [ADDR_W-1:0]        raddr_b_i,
    output vec_cfg_pkg::elem_t      rdata_a_o,
    output vec_cfg_pkg::elem_t      rdata_b_o,
    input  wire                     we_i,
    input  wire [ADDR_W-1:0]        waddr_i,
    input  wire vec_cfg_pkg::elem_t wdata_i
);

    vec_cfg_pkg::elem_t mem_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
        rdata_a_o <= mem_q[raddr_a_i];  // Old data on a same-address write
        rdata_b_o <= mem_q[raddr_b_i];
    end

endmodule

`default_nettype wire

// File: rtl/vector_lane.sv
/* One vector lane: register-file read stage, then execute and write-back into
   the lane's own bank from the ALU, the load word or the slide ring */
`timescale 1ns/1ps
`default_nettype none

module vector_lane #(
    parameter int ELEMS_PER_LANE = 2
) (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire vec_isa_pkg::row_ctrl_t ctrl_i,
    input  wire vec_cfg_pkg::elem_t     load_data_i,
    input  wire vec_cfg_pkg::elem_t     slide_data_i,
    output vec_cfg_pkg::elem_t          slide_data_o,
    output vec_cfg_pkg::elem_t          rd_data_o,
    output logic                        store_valid_o
);

    localparam int ADDR_W = $clog2(vec_cfg_pkg::VREG_NUM * ELEMS_PER_LANE);

    vec_isa_pkg::row_ctrl_t ctrl_q;
    vec_cfg_pkg::elem_t     load_q;
    vec_cfg_pkg::elem_t     rdata_a;
    vec_cfg_pkg::elem_t     rdata_b;
    vec_cfg_pkg::elem_t     alu_y;
    vec_cfg_pkg::elem_t     wdata;
    logic [ADDR_W-1:0]      raddr_a;
    logic [ADDR_W-1:0]      raddr_b;
    logic [ADDR_W-1:0]      waddr;
    logic                   we;

    // Register-major layout, rows of one register are adjacent
    function automatic logic [ADDR_W-1:0] bank_addr(
        input vec_cfg_pkg::vreg_idx_t         vreg,
        input logic [vec_cfg_pkg::ROW_W-1:0] row
    );
        return ADDR_W'(int'(vreg) * ELEMS_PER_LANE + int'(row));
    endfunction

    ////////////////////
    // Read stage
    assign raddr_a = bank_addr(ctrl_i.vs1, ctrl_i.row);
    assign raddr_b = bank_addr(ctrl_i.vs2, ctrl_i.row);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl_i;
        end
    end

    always_ff @(posedge clk_i) begin
        load_q <= load_data_i;
    end

    vrf_bank #(
        .ELEMS_PER_LANE(ELEMS_PER_LANE)
    ) vrf_bank_inst (
        .clk_i    (clk_i),
        .raddr_a_i(raddr_a),
        .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a),
        .rdata_b_o(rdata_b),
        .we_i     (we),
        .waddr_i  (waddr),
        .wdata_i  (wdata)
    );

    ////////////////////
    // Execute and write
    lane_alu lane_alu_inst (
        .fn_i(ctrl_q.fn),
        .a_i (rdata_a),
        .b_i (rdata_b),
        .y_o (alu_y)
    );

    always_comb begin
        case (ctrl_q.wb_src)
            vec_isa_pkg::WB_LOAD:  wdata = load_q;
            vec_isa_pkg::WB_SLIDE: wdata = slide_data_i;
            default:               wdata = alu_y;
        endcase
    end

    assign we            = ctrl_q.valid && (ctrl_q.wb_src != vec_isa_pkg::WB_NONE);
    assign waddr         = bank_addr(ctrl_q.vd, ctrl_q.row);
    assign slide_data_o  = rdata_a;  // vs1 element onto the ring
    assign rd_data_o     = rdata_a;
    assign store_valid_o = ctrl_q.valid && ctrl_q.store_row;

endmodule

`default_nettype wire

// File: rtl/lane_interconnect.sv
/* Registers row control and load words once and fans them out to the lanes,
   and rotates the lanes' slide data one lane around the ring */
`timescale 1ns/1ps
`default_nettype none

module lane_interconnect #(
    parameter int VLANE_NUM = 4
) (
    input  wire                                     clk_i,
    input  wire                                     rst_n_i,
    input  wire vec_isa_pkg::row_ctrl_t             row_ctrl_i,
    input  wire vec_cfg_pkg::elem_t [VLANE_NUM-1:0] load_row_i,
    output vec_isa_pkg::row_ctrl_t [VLANE_NUM-1:0]  lane_ctrl_o,
    output vec_cfg_pkg::elem_t [VLANE_NUM-1:0]      lane_load_o,
    input  wire vec_cfg_pkg::elem_t [VLANE_NUM-1:0] slide_data_i,
    output vec_cfg_pkg::elem_t [VLANE_NUM-1:0]      slide_data_o
);

    vec_isa_pkg::row_ctrl_t             ctrl_q;
    vec_cfg_pkg::elem_t [VLANE_NUM-1:0] load_q;
    logic                               slide_up_q;  // Lines up with the lane read data

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q     <= '0;
            slide_up_q <= 1'b0;
        end else begin
            ctrl_q     <= row_ctrl_i;
            slide_up_q <= ctrl_q.slide_up;
        end
    end

    always_ff @(posedge clk_i) begin
        load_q <= load_row_i;
    end

    for (genvar l = 0; l < VLANE_NUM; l++) begin : g_fanout
        assign lane_ctrl_o[l] = ctrl_q;
        assign lane_load_o[l] = load_q[l];
        // Up takes the lower neighbour, down the upper one, both wrapping
        assign slide_data_o[l] = slide_up_q ? slide_data_i[(l + VLANE_NUM - 1) % VLANE_NUM]
                                            : slide_data_i[(l + 1) % VLANE_NUM];
    end

endmodule

`default_nettype wire

// File: rtl/load_buffer.sv
/* Show-ahead FIFO of incoming load rows; every pop hands one credit back to the sender */
`timescale 1ns/1ps
`default_nettype none

module load_buffer #(
    parameter int VLANE_NUM      = 4,
    parameter int LOAD_BUF_DEPTH = 4
) (
    input  wire                                     clk_i,
    input  wire                                     rst_n_i,
    input  wire                                     push_i,
    input  wire vec_cfg_pkg::elem_t [VLANE_NUM-1:0] push_row_i,
    input  wire                                     pop_i,
    output vec_cfg_pkg::elem_t [VLANE_NUM-1:0]      pop_row_o,
    output logic                                    not_empty_o,
    output logic                                    credit_o
);

    localparam int PTR_W = (LOAD_BUF_DEPTH > 1) ? $clog2(LOAD_BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(LOAD_BUF_DEPTH + 1);

    vec_cfg_pkg::elem_t [VLANE_NUM-1:0] mem_q [LOAD_BUF_DEPTH];
    logic [PTR_W-1:0]                   wr_ptr_q;
    logic [PTR_W-1:0]                   rd_ptr_q;
    logic [CNT_W-1:0]                   count_q;
    logic                               do_push;
    logic                               do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(LOAD_BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign not_empty_o = (count_q != '0);
    assign do_pop      = pop_i && not_empty_o;
    assign do_push     = push_i && (count_q != CNT_W'(LOAD_BUF_DEPTH));
    assign pop_row_o   = mem_q[rd_ptr_q];  // Head row

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_row_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q  <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
            credit_o <= do_pop;  // One credit per freed entry
        end
    end

endmodule

`default_nettype wire

// File: rtl/vec_seq_driver.sv
/* Accepts one instruction at a time, decodes it and issues its rows to the lanes,
   stalling on an empty load buffer or on exhausted store credits */
`timescale 1ns/1ps
`default_nettype none

module vec_seq_driver #(
    parameter int ELEMS_PER_LANE = 2,
    parameter int STORE_CREDITS  = 2
) (
    input  wire                          clk_i,
    input  wire                          rst_n_i,
    input  wire vec_isa_pkg::vec_instr_u instr_i,
    input  wire                          instr_valid_i,
    output logic                         instr_ready_o,
    input  wire                          load_avail_i,
    output logic                         load_pop_o,
    input  wire                          store_credit_i,
    output vec_isa_pkg::row_ctrl_t       row_ctrl_o
);

    localparam int CRED_W = $clog2(STORE_CREDITS + 1);
    localparam int ROW_W  = vec_cfg_pkg::ROW_W;

    vec_isa_pkg::row_ctrl_t dec;
    vec_isa_pkg::row_ctrl_t tmpl_q;  // Decoded fields of the current instruction
    logic                   busy_q;
    logic [ROW_W-1:0]       row_q;
    logic [1:0]             drain_q;
    logic [CRED_W-1:0]      credits_q;
    logic                   accept;
    logic                   res_ok;
    logic                   issue;
    logic                   last_row;
    logic                   store_issue;

    assign accept = instr_valid_i && instr_ready_o;

    ////////////////////
    // Decode
    always_comb begin
        dec = '0;
        dec.vd  = instr_i.alu.vd;
        dec.vs1 = instr_i.alu.vs1;
        dec.vs2 = instr_i.alu.vs2;
        dec.fn  = instr_i.alu.fn;
        case (instr_i.alu.opcode)
            vec_isa_pkg::OP_ALU: dec.wb_src = vec_isa_pkg::WB_ALU;
            vec_isa_pkg::OP_LOAD: begin
                dec.vd     = instr_i.mem.vreg;
                dec.wb_src = vec_isa_pkg::WB_LOAD;
            end
            vec_isa_pkg::OP_STORE: begin
                dec.vs1       = instr_i.mem.vreg;  // Store data comes from the vs1 read
                dec.wb_src    = vec_isa_pkg::WB_NONE;
                dec.store_row = 1'b1;
            end
            vec_isa_pkg::OP_SLIDE_UP: begin
                dec.wb_src   = vec_isa_pkg::WB_SLIDE;
                dec.slide_up = 1'b1;
            end
            vec_isa_pkg::OP_SLIDE_DOWN: dec.wb_src = vec_isa_pkg::WB_SLIDE;
            default: dec.wb_src = vec_isa_pkg::WB_NONE;  // Unknown opcode, rows do nothing
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            tmpl_q <= dec;
        end
    end

    ////////////////////
    // Issue
    assign res_ok = (tmpl_q.wb_src == vec_isa_pkg::WB_LOAD) ? load_avail_i :
                    tmpl_q.store_row ? (credits_q != '0) : 1'b1;
    assign issue       = busy_q && res_ok;
    assign last_row    = (row_q == ROW_W'(ELEMS_PER_LANE - 1));
    assign store_issue = issue && tmpl_q.store_row;
    assign load_pop_o  = issue && (tmpl_q.wb_src == vec_isa_pkg::WB_LOAD);

    always_comb begin
        row_ctrl_o       = tmpl_q;
        row_ctrl_o.valid = issue;
        row_ctrl_o.row   = row_q;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q        <= 1'b0;
            row_q         <= '0;
            drain_q       <= '0;
            instr_ready_o <= 1'b1;
        end else begin
            if (accept) begin
                busy_q        <= 1'b1;
                row_q         <= '0;
                instr_ready_o <= 1'b0;
            end else if (issue) begin
                if (last_row) begin
                    busy_q  <= 1'b0;
                    drain_q <= 2'd2;  // Ready again 3 cycles after the last row
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end
            if (drain_q != '0) begin
                drain_q <= drain_q - 1'b1;
                if (drain_q == 2'd1) begin
                    instr_ready_o <= 1'b1;
                end
            end
        end
    end

    // Store credits, spent at issue and returned by the receiver
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credits_q <= CRED_W'(STORE_CREDITS);
        end else begin
            credits_q <= credits_q - CRED_W'(store_issue) + CRED_W'(store_credit_i);
        end
    end

endmodule

`default_nettype wire

// File: rtl/vec_unit_top.sv
/* Vector execution unit top level, wiring the sequencing driver, load buffer,
   lane interconnect and the lane array; the store row is gathered from the lanes */
`timescale 1ns/1ps
`default_nettype none

module vec_unit_top #(
    parameter int VLANE_NUM      = 4,
    parameter int ELEMS_PER_LANE = 2,
    parameter int LOAD_BUF_DEPTH = 4,
    parameter int STORE_CREDITS  = 2
) (
    input  wire                                     clk_i,
    input  wire                                     rst_n_i,
    // Instruction handshake
    input  wire vec_isa_pkg::vec_instr_u            instr_i,
    input  wire                                     instr_valid_i,
    output logic                                    instr_ready_o,
    // Load rows, credit based
    input  wire                                     load_valid_i,
    input  wire vec_cfg_pkg::elem_t [VLANE_NUM-1:0] load_row_i,
    output logic                                    load_credit_o,
    // Store rows, credit based
    input  wire                                     store_credit_i,
    output logic                                    store_valid_o,
    output vec_cfg_pkg::elem_t [VLANE_NUM-1:0]      store_row_o
);

    ////////////////////
    // Connecting signals
    vec_isa_pkg::row_ctrl_t                  drv_ctrl;
    logic                                    load_pop;
    logic                                    load_avail;
    vec_cfg_pkg::elem_t [VLANE_NUM-1:0]      buf_row;
    vec_isa_pkg::row_ctrl_t [VLANE_NUM-1:0]  lane_ctrl;
    vec_cfg_pkg::elem_t [VLANE_NUM-1:0]      lane_load;
    vec_cfg_pkg::elem_t [VLANE_NUM-1:0]      slide_from_lane;
    vec_cfg_pkg::elem_t [VLANE_NUM-1:0]      slide_to_lane;
    logic [VLANE_NUM-1:0]                    lane_store;
    ////////////////////

    vec_seq_driver #(
        .ELEMS_PER_LANE(ELEMS_PER_LANE),
        .STORE_CREDITS (STORE_CREDITS)
    ) vec_seq_driver_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .load_avail_i  (load_avail),
        .load_pop_o    (load_pop),
        .store_credit_i(store_credit_i),
        .row_ctrl_o    (drv_ctrl)
    );

    load_buffer #(
        .VLANE_NUM     (VLANE_NUM),
        .LOAD_BUF_DEPTH(LOAD_BUF_DEPTH)
    ) load_buffer_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .push_i     (load_valid_i),
        .push_row_i (load_row_i),
        .pop_i      (load_pop),
        .pop_row_o  (buf_row),
        .not_empty_o(load_avail),
        .credit_o   (load_credit_o)
    );

    lane_interconnect #(
        .VLANE_NUM(VLANE_NUM)
    ) lane_interconnect_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .row_ctrl_i  (drv_ctrl),
        .load_row_i  (buf_row),
        .lane_ctrl_o (lane_ctrl),
        .lane_load_o (lane_load),
        .slide_data_i(slide_from_lane),
        .slide_data_o(slide_to_lane)
    );

    for (genvar l = 0; l < VLANE_NUM; l++) begin : g_lane
        vector_lane #(
            .ELEMS_PER_LANE(ELEMS_PER_LANE)
        ) vector_lane_inst (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .ctrl_i       (lane_ctrl[l]),
            .load_data_i  (lane_load[l]),
            .slide_data_i (slide_to_lane[l]),
            .slide_data_o (slide_from_lane[l]),
            .rd_data_o    (store_row_o[l]),  // Word l of the store row
            .store_valid_o(lane_store[l])
        );
    end

    assign store_valid_o = lane_store[0];  // All lanes stage the same flag

endmodule

`default_nettype wire

// File: verification/tb_vec_unit.sv
/* Testbench of the vector unit; replays instruction and load records from the stimulus
   file, returns store credits at random and checks each store row against its record */
`timescale 1ns/1ps
`default_nettype none

module tb_vec_unit;

    localparam int VLANE_NUM      = 4;
    localparam int ELEMS_PER_LANE = 2;
    localparam int LOAD_BUF_DEPTH = 4;
    localparam int STORE_CREDITS  = 2;
    localparam int SEED           = 32'h6633b62b;
    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_MARGIN = 200;
    localparam int MAX_REC        = 64;
    localparam int REC_WORDS      = 1 + VLANE_NUM;  // Kind word, then one word per lane
    localparam int ROW_BITS       = VLANE_NUM * vec_cfg_pkg::DATA_W;

    // Record kinds in the stimulus file
    localparam int REC_INSTR = 1;
    localparam int REC_LOAD  = 2;
    localparam int REC_GAP   = 3;
    localparam int REC_STORE = 4;

    typedef vec_cfg_pkg::elem_t [VLANE_NUM-1:0] row_t;

    typedef struct packed {
        logic        gap;     // Idle the load sender instead of pushing
        logic [31:0] cycles;
        row_t        row;
    } load_rec_t;

    logic                    clk;
    logic                    rst_n;
    vec_isa_pkg::vec_instr_u instr;
    logic                    instr_valid;
    logic                    instr_ready;
    logic                    load_valid;
    row_t                    load_row;
    logic                    load_credit;
    logic                    store_credit;
    logic                    store_valid;
    row_t                    store_row;

    logic [31:0] stim_mem [MAX_REC*REC_WORDS];
    logic [15:0] instr_list[$];
    load_rec_t   load_list[$];
    row_t        exp_list[$];

    int rec_count         = 0;
    int exp_total         = 0;
    int checks            = 0;
    int errors            = 0;
    int other_fails       = 0;
    int timeout_limit     = 0;
    int cycle_count       = 0;
    int stores_seen       = 0;
    int credits_given     = 0;
    int rows_pushed       = 0;
    int load_credits_back = 0;
    bit started           = 1'b0;
    bit instr_done        = 1'b0;

    vec_unit_top #(
        .VLANE_NUM     (VLANE_NUM),
        .ELEMS_PER_LANE(ELEMS_PER_LANE),
        .LOAD_BUF_DEPTH(LOAD_BUF_DEPTH),
        .STORE_CREDITS (STORE_CREDITS)
    ) vec_unit_top_i (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .instr_ready_o (instr_ready),
        .load_valid_i  (load_valid),
        .load_row_i    (load_row),
        .load_credit_o (load_credit),
        .store_credit_i(store_credit),
        .store_valid_o (store_valid),
        .store_row_o   (store_row)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_value(input string what, input logic [ROW_BITS-1:0] got,
                               input logic [ROW_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic close_run();
        $display("Checks: %0d, value errors: %0d, other failures: %0d",
                 checks, errors, other_fails);
        if (errors == 0 && other_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // Splits the flat word image into the three streams
    task automatic parse_records();
        int          r;
        int          l;
        logic [31:0] kind;
        row_t        row;
        load_rec_t   rec;
        for (r = 0; r < MAX_REC; r++) begin
            kind = stim_mem[r*REC_WORDS];
            if (kind == 0) break;  // End of records
            for (l = 0; l < VLANE_NUM; l++) begin
                row[l] = stim_mem[r*REC_WORDS + 1 + l];
            end
            rec_count++;
            case (kind)
                REC_INSTR: instr_list.push_back(row[0][15:0]);
                REC_LOAD: begin
                    rec = '{gap: 1'b0, cycles: '0, row: row};
                    load_list.push_back(rec);
                end
                REC_GAP: begin
                    rec = '{gap: 1'b1, cycles: row[0], row: '0};
                    load_list.push_back(rec);
                end
                REC_STORE: begin
                    exp_list.push_back(row);
                    exp_total++;
                end
                default: begin
                    other_fails++;
                    $display("Stimulus record %0d has an unknown kind %0h", r, kind);
                end
            endcase
        end
    endtask

    initial begin : main
        int i;
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr        = '0;
        instr_valid  = 1'b0;
        load_valid   = 1'b0;
        load_row     = '0;
        store_credit = 1'b0;
        for (i = 0; i < MAX_REC*REC_WORDS; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("verification/vec_stimulus.txt", stim_mem);
        parse_records();
        if (rec_count == 0) begin
            other_fails++;
            $display("The stimulus file is missing or holds no records");
        end
        timeout_limit = rec_count * 20 + TIMEOUT_MARGIN;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("instr_ready_o after reset", instr_ready, 1);
        check_value("store_valid_o after reset", store_valid, 0);
        check_value("load_credit_o after reset", load_credit, 0);
        started = 1'b1;
        while (!(instr_done && stores_seen >= exp_total)) @(negedge clk);
        repeat (8) @(negedge clk);  // Catch stray rows and late credits
        check_value("store rows seen", stores_seen, exp_total);
        check_value("load credits returned", load_credits_back, rows_pushed);
        close_run();
    end

    initial begin : issue_instructions
        int low_cycles;
        wait (started);
        while (instr_list.size() > 0) begin
            @(negedge clk);
            while (!instr_ready) @(negedge clk);
            instr       = instr_list.pop_front();
            instr_valid = 1'b1;
            @(negedge clk);
            instr_valid = 1'b0;
            low_cycles  = 0;
            while (!instr_ready) begin
                low_cycles++;
                @(negedge clk);
            end
            // Rows plus drain set the shortest busy time
            if (low_cycles < ELEMS_PER_LANE + 2) begin
                other_fails++;
                $display("Instruction %h finished after only %0d cycles", instr, low_cycles);
            end
        end
        instr_done = 1'b1;
    end

    initial begin : push_loads
        int        credits;
        int        gap_left;
        load_rec_t rec;
        credits  = LOAD_BUF_DEPTH;
        gap_left = 0;
        wait (started);
        forever begin
            @(negedge clk);
            load_valid = 1'b0;
            if (load_credit) begin
                credits++;
                load_credits_back++;
            end
            if (gap_left > 0) begin
                gap_left--;
            end else if (load_list.size() > 0 && (load_list[0].gap || credits > 0)) begin
                rec = load_list.pop_front();
                if (rec.gap) begin
                    gap_left = rec.cycles;
                end else begin
                    load_row   = rec.row;
                    load_valid = 1'b1;
                    credits--;
                    rows_pushed++;
                end
            end
        end
    end

    initial begin : return_store_credits
        int   gap;
        row_t exp_row;
        gap = 0;
        wait (started);
        forever begin
            @(negedge clk);
            store_credit = 1'b0;
            if (store_valid) begin
                stores_seen++;
                if (exp_list.size() == 0) begin
                    other_fails++;
                    $display("A store row arrived at %0t with no expected record left", $time);
                end else begin
                    exp_row = exp_list.pop_front();
                    check_value($sformatf("store row %0d", stores_seen), store_row, exp_row);
                end
                if (stores_seen - credits_given > STORE_CREDITS) begin
                    other_fails++;
                    $display("More store rows outstanding than credits at %0t", $time);
                end
            end
            if (stores_seen > credits_given) begin
                if (gap == 0) begin
                    store_credit = 1'b1;
                    credits_given++;
                    gap = $urandom_range(5, 0);
                end else begin
                    gap--;
                end
            end
        end
    end

    initial begin : watchdog
        wait (started);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        other_fails++;
        $display("Simulation timed out after %0d cycles", cycle_count);
        close_run();
    end

endmodule

`default_nettype wire

// File: verification/vec_stimulus.txt
// Columns: kind word0 word1 word2 word3 (hex), word n belongs to lane n
// Kind 1 instruction in word0, 2 load row, 3 load gap of word0 cycles, 4 expected store row
// Loads of v1 and v2, then v6 whose rows arrive late
1 2400 0 0 0
1 2800 0 0 0
1 3800 0 0 0
1 5800 0 0 0
1 4400 0 0 0
2 00000011 00000022 00000033 00000044
2 00000055 00000066 00000077 00000088
2 00000003 00000005 00000010 00000001
2 00000002 00000004 00000100 000000ff
3 00000028 0 0 0
2 deadbeef 12345678 0000ffff a5a5a5a5
2 cafef00d 0badc0de 80000001 7ffffffe
4 deadbeef 12345678 0000ffff a5a5a5a5
4 cafef00d 0badc0de 80000001 7ffffffe
4 00000011 00000022 00000033 00000044
4 00000055 00000066 00000077 00000088
// v3 = v1 fn v2 for every ALU function, each stored back
1 0194 0 0 0
1 4c00 0 0 0
4 00000014 00000027 00000043 00000045
4 00000057 0000006a 00000177 00000187
1 0594 0 0 0
1 4c00 0 0 0
4 0000000e 0000001d 00000023 00000043
4 00000053 00000062 ffffff77 ffffff89
1 0994 0 0 0
1 4c00 0 0 0
4 00000001 00000000 00000010 00000000
4 00000000 00000004 00000000 00000088
1 0d94 0 0 0
1 4c00 0 0 0
4 00000013 00000027 00000033 00000045
4 00000057 00000066 00000177 000000ff
1 1194 0 0 0
1 4c00 0 0 0
4 00000012 00000027 00000023 00000045
4 00000057 00000062 00000177 00000077
1 1594 0 0 0
1 4c00 0 0 0
4 00000088 00000440 00330000 00000088
4 00000154 00000660 00000077 00000000
1 1994 0 0 0
1 4c00 0 0 0
4 00000002 00000001 00000000 00000022
4 00000015 00000006 00000077 00000000
1 1d94 0 0 0
1 4c00 0 0 0
4 00000003 00000005 00000010 00000001
4 00000002 00000004 00000077 00000088
// Slide up of v1 into v4, slide down of v1 into v5
1 6210 0 0 0
1 5000 0 0 0
4 00000044 00000011 00000022 00000033
4 00000088 00000055 00000066 00000077
1 8290 0 0 0
1 5400 0 0 0
4 00000022 00000033 00000044 00000011
4 00000066 00000077 00000088 00000055

// File: verilog.f
rtl/vec_cfg_pkg.sv
rtl/vec_isa_pkg.sv
rtl/lane_alu.sv
rtl/vrf_bank.sv
rtl/vector_lane.sv
rtl/lane_interconnect.sv
rtl/load_buffer.sv
rtl/vec_seq_driver.sv
rtl/vec_unit_top.sv
verification/tb_vec_unit.sv

// File: run_sim.sh
#!/bin/sh
# Builds the vector unit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f verilog.f \
    --top-module tb_vec_unit \
    -o tb_vec_unit

./obj_dir/tb_vec_unit | tee "$LOG"

if grep -q "Finished with no errors" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
